// File: verilog/pipe_defines.svh
//////////////////////////////////////////////////
// Datapath sizes shared by every pipeline stage
// PIPE_REG_COUNT must equal 2**PIPE_REG_AW
//////////////////////////////////////////////////
`ifndef PIPE_DEFINES_SVH
`define PIPE_DEFINES_SVH

// Data and ALU operand width
`define PIPE_WIDTH 32

// Register file address width and depth
`define PIPE_REG_AW 4
`define PIPE_REG_COUNT 16

// Immediate field in the instruction word
`define PIPE_IMM_W 16

// Opcode field in the instruction word
`define PIPE_OP_W 4

`endif

// File: verilog/pipe_pkg.sv
//////////////////////////////////////////////////
// Opcodes, operand selects and stage records
// Opcode codes not listed here decode as NOP
//////////////////////////////////////////////////
`include "pipe_defines.svh"

package pipe_pkg;

	// ALU opcodes, taken from instruction bits 31..28
	typedef enum logic [`PIPE_OP_W-1:0] {
		NOP  = 4'd0,
		ADD  = 4'd1,
		SUB  = 4'd2,
		AND  = 4'd3,
		OR   = 4'd4,
		XOR  = 4'd5,
		ADDI = 4'd6,
		ORI  = 4'd7
	} alu_op_e;

	// Operand source chosen by decode
	typedef enum logic [1:0] {
		SEL_RF      = 2'd0,
		SEL_IMM     = 2'd1,
		SEL_EX_FORW = 2'd2,
		SEL_WB_FORW = 2'd3
	} opnd_sel_e;

	// Decode to EX control, all zero is a bubble
	typedef struct packed {
		logic                    valid;
		alu_op_e                 op;
		logic [`PIPE_REG_AW-1:0] rd;
	} id_ctrl_t;

	// Writeback register contents
	typedef struct packed {
		logic                    valid;
		logic [`PIPE_REG_AW-1:0] rd;
		logic [`PIPE_WIDTH-1:0]  result;
	} ex_wb_t;

endpackage

// File: verilog/reg_file.sv
//////////////////////////////////////////////////
// 16 x 32 register file, two async read ports
// No write-to-read bypass, r0 always reads zero
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "pipe_defines.svh"

module reg_file (
	input  logic                    clk,
	input  logic                    rst_n,
	// Read ports
	input  logic [`PIPE_REG_AW-1:0] ra,
	input  logic [`PIPE_REG_AW-1:0] rb,
	output logic [`PIPE_WIDTH-1:0]  rf_data_a,
	output logic [`PIPE_WIDTH-1:0]  rf_data_b,
	// Write port from WB
	input  logic                    we,
	input  logic [`PIPE_REG_AW-1:0] wa,
	input  logic [`PIPE_WIDTH-1:0]  wd
);

	// Register array
	logic [`PIPE_WIDTH-1:0] mem [`PIPE_REG_COUNT];

	//////////////////////////////////////////////////
	// Write port
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			// Whole array cleared so early reads see zero
			for (int i = 0; i < `PIPE_REG_COUNT; i++)
				mem[i] <= '0;
		end else if (we && wa != '0) begin
			// r0 is never written
			mem[wa] <= wd;
		end
	end

	//////////////////////////////////////////////////
	// Read ports
	//////////////////////////////////////////////////

	// Old value during a write cycle, WB forward covers it
	assign rf_data_a = mem[ra];
	assign rf_data_b = mem[rb];

endmodule

// File: verilog/insn_decode.sv
//////////////////////////////////////////////////
// Instruction register and decode stage
// Forwarding priority is EX first, then WB
// r0 never forwards, unknown opcodes act as NOP
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "pipe_defines.svh"

module insn_decode (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    id_freeze,
	input  logic [`PIPE_WIDTH-1:0]  insn,
	// Register addresses and read data
	output logic [`PIPE_REG_AW-1:0] ra,
	output logic [`PIPE_REG_AW-1:0] rb,
	output logic [`PIPE_WIDTH-1:0]  rf_data_a,
	output logic [`PIPE_WIDTH-1:0]  rf_data_b,
	// Register file write port from WB
	input  logic                    wb_we,
	input  logic [`PIPE_REG_AW-1:0] wb_addr,
	input  logic [`PIPE_WIDTH-1:0]  wb_data,
	// To operand stage
	output logic [`PIPE_WIDTH-1:0]  imm_ext,
	output pipe_pkg::opnd_sel_e     sel_a,
	output pipe_pkg::opnd_sel_e     sel_b,
	output pipe_pkg::id_ctrl_t      id_ctrl,
	// Destinations further down the pipe
	input  logic                    ex_rd_valid,
	input  logic [`PIPE_REG_AW-1:0] ex_rd,
	input  logic                    wb_rd_valid,
	input  logic [`PIPE_REG_AW-1:0] wb_rd
);

	logic [`PIPE_WIDTH-1:0] ir;
	logic [`PIPE_IMM_W-1:0] imm;
	pipe_pkg::alu_op_e      op_raw;
	pipe_pkg::alu_op_e      op;

	// Source select for one register operand
	function automatic pipe_pkg::opnd_sel_e fwd_sel(
		input logic [`PIPE_REG_AW-1:0] src,
		input logic                    ex_v,
		input logic [`PIPE_REG_AW-1:0] ex_r,
		input logic                    wb_v,
		input logic [`PIPE_REG_AW-1:0] wb_r
	);
		if (src == '0)
			return pipe_pkg::SEL_RF;
		if (ex_v && ex_r == src)
			return pipe_pkg::SEL_EX_FORW;
		if (wb_v && wb_r == src)
			return pipe_pkg::SEL_WB_FORW;
		return pipe_pkg::SEL_RF;
	endfunction

	// Instruction register, held while ID is frozen
	always_ff @(posedge clk) begin
		if (!rst_n)
			ir <= '0;
		else if (!id_freeze)
			ir <= insn;
	end

	//////////////////////////////////////////////////
	// Field decode
	//////////////////////////////////////////////////
	assign ra  = ir[23:20];
	assign rb  = ir[19:16];
	assign imm = ir[`PIPE_IMM_W-1:0];

	always_comb begin
		op_raw = pipe_pkg::alu_op_e'(ir[31:28]);
		case (op_raw)
			pipe_pkg::ADD, pipe_pkg::SUB, pipe_pkg::AND, pipe_pkg::OR,
			pipe_pkg::XOR, pipe_pkg::ADDI, pipe_pkg::ORI:
				op = op_raw;
			default:
				op = pipe_pkg::NOP;
		endcase
	end

	// ADDI sign-extends, ORI and the rest zero-extend
	assign imm_ext = (op == pipe_pkg::ADDI) ?
		{{(`PIPE_WIDTH-`PIPE_IMM_W){imm[`PIPE_IMM_W-1]}}, imm} :
		{{(`PIPE_WIDTH-`PIPE_IMM_W){1'b0}}, imm};

	// Forwarding selects, immediate forms take B from imm_ext
	always_comb begin
		sel_a = fwd_sel(ra, ex_rd_valid, ex_rd, wb_rd_valid, wb_rd);
		if (op == pipe_pkg::ADDI || op == pipe_pkg::ORI)
			sel_b = pipe_pkg::SEL_IMM;
		else
			sel_b = fwd_sel(rb, ex_rd_valid, ex_rd, wb_rd_valid, wb_rd);
	end

	// NOP carries no valid bit so it never writes back
	assign id_ctrl.valid = (op != pipe_pkg::NOP);
	assign id_ctrl.op    = op;
	assign id_ctrl.rd    = ir[27:24];

	// Register file, read data goes straight out
	reg_file u_rf (
		.clk       (clk),
		.rst_n     (rst_n),
		.ra        (ra),
		.rb        (rb),
		.rf_data_a (rf_data_a),
		.rf_data_b (rf_data_b),
		.we        (wb_we),
		.wa        (wb_addr),
		.wd        (wb_data)
	);

endmodule

// File: verilog/operand_stage.sv
//////////////////////////////////////////////////
// Operand muxes and EX input registers
// ex_freeze may only be high while id_freeze is
// A held instruction has its operands saved once
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "pipe_defines.svh"

module operand_stage (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   id_freeze,
	input  logic                   ex_freeze,
	// Operand sources
	input  logic [`PIPE_WIDTH-1:0] rf_data_a,
	input  logic [`PIPE_WIDTH-1:0] rf_data_b,
	input  logic [`PIPE_WIDTH-1:0] ex_forw,
	input  logic [`PIPE_WIDTH-1:0] wb_forw,
	input  logic [`PIPE_WIDTH-1:0] imm_ext,
	input  pipe_pkg::opnd_sel_e    sel_a,
	input  pipe_pkg::opnd_sel_e    sel_b,
	input  pipe_pkg::id_ctrl_t     id_ctrl,
	// EX stage inputs
	output logic [`PIPE_WIDTH-1:0] operand_a,
	output logic [`PIPE_WIDTH-1:0] operand_b,
	output pipe_pkg::id_ctrl_t     ex_ctrl
);

	// Index 0 is operand A, index 1 is operand B
	logic [`PIPE_WIDTH-1:0] muxed [2];
	logic [`PIPE_WIDTH-1:0] operand_q [2];
	logic [1:0]             saved;

	// One operand source mux
	function automatic logic [`PIPE_WIDTH-1:0] opnd_mux(
		input pipe_pkg::opnd_sel_e    sel,
		input logic [`PIPE_WIDTH-1:0] rf,
		input logic [`PIPE_WIDTH-1:0] exf,
		input logic [`PIPE_WIDTH-1:0] wbf,
		input logic [`PIPE_WIDTH-1:0] imm
	);
		case (sel)
			pipe_pkg::SEL_IMM:     return imm;
			pipe_pkg::SEL_EX_FORW: return exf;
			pipe_pkg::SEL_WB_FORW: return wbf;
			default:               return rf;
		endcase
	endfunction

	//////////////////////////////////////////////////
	// Source muxes
	//////////////////////////////////////////////////

	// Decode never selects the immediate for A
	always_comb begin
		muxed[0] = opnd_mux(sel_a, rf_data_a, ex_forw, wb_forw, imm_ext);
		muxed[1] = opnd_mux(sel_b, rf_data_b, ex_forw, wb_forw, imm_ext);
	end

	//////////////////////////////////////////////////
	// Operand registers with save flags
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		for (int i = 0; i < 2; i++) begin
			if (!rst_n) begin
				operand_q[i] <= '0;
				saved[i]     <= 1'b0;
			end else if (!ex_freeze && id_freeze && !saved[i]) begin
				// First ID freeze cycle, capture while sources are current
				operand_q[i] <= muxed[i];
				saved[i]     <= 1'b1;
			end else if (!ex_freeze && !saved[i]) begin
				operand_q[i] <= muxed[i];
			end else if (!ex_freeze && !id_freeze) begin
				// Release, keep the saved value for this issue
				saved[i] <= 1'b0;
			end
		end
	end

	assign operand_a = operand_q[0];
	assign operand_b = operand_q[1];

	// EX control holds under ex_freeze, bubble while ID waits
	always_ff @(posedge clk) begin
		if (!rst_n)
			ex_ctrl <= '0;
		else if (!ex_freeze)
			ex_ctrl <= id_freeze ? '0 : id_ctrl;
	end

endmodule

// File: verilog/alu_exec.sv
//////////////////////////////////////////////////
// ALU execute stage and writeback register
// ex_forw is combinational from the EX operands
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "pipe_defines.svh"

module alu_exec (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    ex_freeze,
	input  logic [`PIPE_WIDTH-1:0]  operand_a,
	input  logic [`PIPE_WIDTH-1:0]  operand_b,
	input  pipe_pkg::id_ctrl_t      ex_ctrl,
	// Forward value and EX destination for decode
	output logic [`PIPE_WIDTH-1:0]  ex_forw,
	output logic                    ex_rd_valid,
	output logic [`PIPE_REG_AW-1:0] ex_rd,
	// Writeback register
	output pipe_pkg::ex_wb_t        wb
);

	logic [`PIPE_WIDTH-1:0] alu_res;

	//////////////////////////////////////////////////
	// ALU
	//////////////////////////////////////////////////
	always_comb begin
		case (ex_ctrl.op)
			pipe_pkg::ADD,
			pipe_pkg::ADDI: alu_res = operand_a + operand_b;
			pipe_pkg::SUB:  alu_res = operand_a - operand_b;
			pipe_pkg::AND:  alu_res = operand_a & operand_b;
			pipe_pkg::OR,
			pipe_pkg::ORI:  alu_res = operand_a | operand_b;
			pipe_pkg::XOR:  alu_res = operand_a ^ operand_b;
			// NOP and bubbles
			default:        alu_res = '0;
		endcase
	end

	// Result forwarded to the operand muxes in the same cycle
	assign ex_forw     = alu_res;
	assign ex_rd_valid = ex_ctrl.valid;
	assign ex_rd       = ex_ctrl.rd;

	//////////////////////////////////////////////////
	// Writeback register
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb <= '0;
		end else if (ex_freeze) begin
			// EX holds its instruction, so WB must not repeat it
			wb <= '0;
		end else begin
			wb.valid  <= ex_ctrl.valid;
			wb.rd     <= ex_ctrl.rd;
			wb.result <= alu_res;
		end
	end

endmodule

// File: verilog/pipe_top.sv
//////////////////////////////////////////////////
// Four stage integer pipeline, no hazard unit
// Freezes are plain levels from the environment
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "pipe_defines.svh"

module pipe_top (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [`PIPE_WIDTH-1:0]  insn,
	input  logic                    id_freeze,
	input  logic                    ex_freeze,
	output logic                    wb_we,
	output logic [`PIPE_REG_AW-1:0] wb_addr,
	output logic [`PIPE_WIDTH-1:0]  wb_data
);

	// Decode to operand stage
	logic [`PIPE_WIDTH-1:0]  rf_data_a;
	logic [`PIPE_WIDTH-1:0]  rf_data_b;
	logic [`PIPE_WIDTH-1:0]  imm_ext;
	pipe_pkg::opnd_sel_e     sel_a;
	pipe_pkg::opnd_sel_e     sel_b;
	pipe_pkg::id_ctrl_t      id_ctrl;

	// Operand stage to EX
	logic [`PIPE_WIDTH-1:0]  operand_a;
	logic [`PIPE_WIDTH-1:0]  operand_b;
	pipe_pkg::id_ctrl_t      ex_ctrl;

	// EX and WB feedback
	logic [`PIPE_WIDTH-1:0]  ex_forw;
	logic                    ex_rd_valid;
	logic [`PIPE_REG_AW-1:0] ex_rd;
	pipe_pkg::ex_wb_t        wb;

	// WB register drives the outputs and the register file port
	assign wb_we   = wb.valid;
	assign wb_addr = wb.rd;
	assign wb_data = wb.result;

	// Read addresses stay inside decode
	insn_decode u_decode (
		.clk         (clk),
		.rst_n       (rst_n),
		.id_freeze   (id_freeze),
		.insn        (insn),
		.ra          (),
		.rb          (),
		.rf_data_a   (rf_data_a),
		.rf_data_b   (rf_data_b),
		.wb_we       (wb_we),
		.wb_addr     (wb_addr),
		.wb_data     (wb_data),
		.imm_ext     (imm_ext),
		.sel_a       (sel_a),
		.sel_b       (sel_b),
		.id_ctrl     (id_ctrl),
		.ex_rd_valid (ex_rd_valid),
		.ex_rd       (ex_rd),
		.wb_rd_valid (wb.valid),
		.wb_rd       (wb.rd)
	);

	operand_stage u_opnd (
		.clk       (clk),
		.rst_n     (rst_n),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.rf_data_a (rf_data_a),
		.rf_data_b (rf_data_b),
		.ex_forw   (ex_forw),
		.wb_forw   (wb.result),
		.imm_ext   (imm_ext),
		.sel_a     (sel_a),
		.sel_b     (sel_b),
		.id_ctrl   (id_ctrl),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.ex_ctrl   (ex_ctrl)
	);

	alu_exec u_exec (
		.clk         (clk),
		.rst_n       (rst_n),
		.ex_freeze   (ex_freeze),
		.operand_a   (operand_a),
		.operand_b   (operand_b),
		.ex_ctrl     (ex_ctrl),
		.ex_forw     (ex_forw),
		.ex_rd_valid (ex_rd_valid),
		.ex_rd       (ex_rd),
		.wb          (wb)
	);

endmodule

// File: verif/pipe_checker.sv
//////////////////////////////////////////////////
// Writeback checker for the pipeline testbench
// Expects writebacks in file order, none for NOP lines
// Latency is only checked when no freeze follows capture
// Samples the WB port on the falling clock edge
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "pipe_defines.svh"

module pipe_checker (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [`PIPE_WIDTH-1:0]  insn,
	input  logic                    id_freeze,
	input  logic                    ex_freeze,
	input  logic                    wb_we,
	input  logic [`PIPE_REG_AW-1:0] wb_addr,
	input  logic [`PIPE_WIDTH-1:0]  wb_data,
	input  logic                    end_of_test,
	output int                      mismatch_count,
	output int                      extra_count,
	output int                      missing_count,
	output int                      late_count
);

	localparam int MAX_LINES  = 64;
	// Edges from capture to the WB port with no freeze in between
	localparam int WB_LATENCY = 2;

	logic [31:0]             stim_mem [3*MAX_LINES];
	logic [`PIPE_REG_AW-1:0] exp_rd [$];
	logic [`PIPE_WIDTH-1:0]  exp_data [$];
	int                      cap_edge [$];
	int                      exp_total   = 0;
	int                      seen        = 0;
	int                      mismatches  = 0;
	int                      extras      = 0;
	int                      missing     = 0;
	int                      lates       = 0;
	int                      edge_no     = 0;
	int                      last_freeze = 0;
	int                      cap;
	logic                    reported    = 1'b0;

	// Only opcodes 1 to 7 write back
	function automatic logic writes_back(input logic [31:0] word);
		return word[31:28] >= 4'd1 && word[31:28] <= 4'd7;
	endfunction

	// Expected writebacks kept in program order
	initial begin
		int n;
		n = 0;
		$readmemh("verif/pipe_stimulus.txt", stim_mem);
		while (n < MAX_LINES && stim_mem[3*n+1] <= 32'd15) begin
			if (writes_back(stim_mem[3*n])) begin
				exp_rd.push_back(stim_mem[3*n+1][`PIPE_REG_AW-1:0]);
				exp_data.push_back(stim_mem[3*n+2]);
			end
			n++;
		end
		exp_total = exp_rd.size();
	end

	assign mismatch_count = mismatches;
	assign extra_count    = extras;
	assign missing_count  = missing;
	assign late_count     = lates;

	// Edge count out of reset with freezes and instruction captures
	always @(posedge clk) begin
		if (rst_n) begin
			edge_no++;
			if (id_freeze || ex_freeze)
				last_freeze = edge_no;
			if (!id_freeze && writes_back(insn))
				cap_edge.push_back(edge_no);
		end
	end

	//////////////////////////////////////////////////
	// Compare each writeback
	//////////////////////////////////////////////////
	always @(negedge clk) begin
		if (rst_n && wb_we) begin
			if (seen < exp_total) begin
				if (wb_addr !== exp_rd[seen]) begin
					$display("[ERROR] wb_addr writeback %0d got 0x%h expected 0x%h",
						seen, wb_addr, exp_rd[seen]);
					mismatches++;
				end
				if (wb_data !== exp_data[seen]) begin
					$display("[ERROR] wb_data writeback %0d got 0x%h expected 0x%h",
						seen, wb_data, exp_data[seen]);
					mismatches++;
				end
				if (cap_edge.size() > 0) begin
					cap = cap_edge.pop_front();
					// A freeze after capture may stretch the latency
					if (last_freeze < cap && edge_no != cap + WB_LATENCY) begin
						$display("Writeback %0d came %0d edges after capture instead of %0d",
							seen, edge_no - cap, WB_LATENCY);
						lates++;
					end
				end
			end else begin
				$display("Writeback to r%0d with 0x%h came after all expected ones",
					wb_addr, wb_data);
				extras++;
			end
			seen++;
		end
	end

	// Anything still queued at the end never came out
	always @(posedge clk) begin
		if (end_of_test && !reported) begin
			for (int i = seen; i < exp_total; i++)
				$display("Expected writeback %0d to r%0d never appeared", i, exp_rd[i]);
			missing  = (exp_total > seen) ? exp_total - seen : 0;
			reported = 1'b1;
		end
	end

endmodule

// File: verif/pipe_tb.sv
//////////////////////////////////////////////////
// Testbench for the four stage pipeline
// Stimulus comes from verif/pipe_stimulus.txt
// Freeze bursts are drawn from a seeded LFSR
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "pipe_defines.svh"

module pipe_tb;

	localparam int MAX_LINES = 64;
	localparam int CLK_NS    = 10;

	// One freeze burst ahead of an instruction
	typedef struct packed {
		logic       active;
		logic [1:0] len;
		logic       both;
	} burst_t;

	logic                    clk;
	logic                    rst_n;
	logic [`PIPE_WIDTH-1:0]  insn;
	logic                    id_freeze;
	logic                    ex_freeze;
	logic                    wb_we;
	logic [`PIPE_REG_AW-1:0] wb_addr;
	logic [`PIPE_WIDTH-1:0]  wb_data;

	// End of test flag and checker counts
	logic                    end_of_test;
	int                      mismatch_count;
	int                      extra_count;
	int                      missing_count;
	int                      late_count;

	// Instruction, rd and result as three words per line
	logic [31:0]             stim_mem [3*MAX_LINES];
	int                      n_lines;
	int                      load_errors = 0;
	logic [15:0]             lfsr;

	pipe_top uut (
		.clk       (clk),
		.rst_n     (rst_n),
		.insn      (insn),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.wb_we     (wb_we),
		.wb_addr   (wb_addr),
		.wb_data   (wb_data)
	);

	pipe_checker chk (
		.clk            (clk),
		.rst_n          (rst_n),
		.insn           (insn),
		.id_freeze      (id_freeze),
		.ex_freeze      (ex_freeze),
		.wb_we          (wb_we),
		.wb_addr        (wb_addr),
		.wb_data        (wb_data),
		.end_of_test    (end_of_test),
		.mismatch_count (mismatch_count),
		.extra_count    (extra_count),
		.missing_count  (missing_count),
		.late_count     (late_count)
	);

	// Fibonacci form of x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// One LFSR step per bit taken with the MSB first
	task automatic draw_bits(input int n, output logic [3:0] val);
		val = '0;
		for (int k = 0; k < n; k++) begin
			val  = {val[2:0], lfsr[15]};
			lfsr = lfsr_step(lfsr);
		end
	endtask

	task automatic pick_burst(output burst_t b);
		logic [3:0] bits;
		draw_bits(1, bits);
		b.active = bits[0];
		draw_bits(2, bits);
		b.len = bits[1:0];
		draw_bits(1, bits);
		b.both = bits[0];
	endtask

	task automatic print_error_counts();
		$display("Errors: mismatch=%0d extra=%0d missing=%0d late=%0d load=%0d",
			mismatch_count, extra_count, missing_count, late_count, load_errors);
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_NS/2) clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Main stimulus
	//////////////////////////////////////////////////
	initial begin
		burst_t burst;
		insn        = '0;
		id_freeze   = 1'b0;
		ex_freeze   = 1'b0;
		rst_n       = 1'b0;
		end_of_test = 1'b0;
		lfsr        = 16'd75;
		n_lines     = 0;
		$readmemh("verif/pipe_stimulus.txt", stim_mem);
		// Destination above r15 marks the end of the list
		while (n_lines < MAX_LINES && stim_mem[3*n_lines+1] <= 32'd15)
			n_lines++;
		if (n_lines == 0) begin
			$display("Stimulus file held no instructions");
			load_errors++;
		end
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		for (int i = 0; i < n_lines; i++) begin
			pick_burst(burst);
			// ID holds the previous instruction while the next one waits on insn
			if (burst.active && burst.len != 2'd0) begin
				insn      = stim_mem[3*i];
				id_freeze = 1'b1;
				ex_freeze = burst.both;
				repeat (burst.len) @(negedge clk);
			end
			insn      = stim_mem[3*i];
			id_freeze = 1'b0;
			ex_freeze = 1'b0;
			@(negedge clk);
		end
		// NOPs flush the pipe while the last result reaches WB two edges after capture
		insn = '0;
		repeat (4) @(negedge clk);
		end_of_test = 1'b1;
		@(negedge clk);
		print_error_counts();
		if (mismatch_count + extra_count + missing_count + late_count + load_errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	// Watchdog allows four cycles per instruction plus reset and flush
	initial begin
		int limit_ns;
		#1;
		limit_ns = (n_lines * 4 + 20) * CLK_NS;
		#(limit_ns);
		$display("Timeout, the run did not finish within %0d ns", limit_ns);
		print_error_counts();
		$display("Something failed");
		$finish;
	end

endmodule

// File: verif/pipe_stimulus.txt
// Each line holds the instruction word, the expected rd and the expected result in hex
// NOP lines carry zeros and write nothing, the line with rd ff ends the list
00000000 0 00000000
// ADD of two registers never written
11230000 1 00000000
// ADDI sign extension and ORI zero extension
62001234 2 00001234
6300fff0 3 fffffff0
74008001 4 00008001
// WB forward on B, register file on A
15230000 5 00001224
// EX forward on A
26540000 6 ffff9223
// EX forward on B
37460000 7 00008001
48270000 8 00009235
59830000 9 ffff6dc5
1a990000 a fffedb8a
2ba80000 b fffe4955
5c9b0000 c 00012490
7dc0f00f d 0001f49f
6ed08000 e 0001749f
// Unknown opcode behaves as NOP
9abc0000 0 00000000
3fed0000 f 0001749f
111f0000 1 0001749f
22010000 2 fffe8b61
53250000 3 fffe9945
44310000 4 fffffddf
// Write to r0 shows on the port but never forwards
10440000 0 fffffbbe
15040000 5 fffffddf
76500220 6 ffffffff
ffffffff ff ffffffff

// File: all.f
+incdir+verilog
verilog/pipe_pkg.sv
verilog/reg_file.sv
verilog/insn_decode.sv
verilog/operand_stage.sv
verilog/alu_exec.sv
verilog/pipe_top.sv
verif/pipe_checker.sv
verif/pipe_tb.sv

// File: Makefile
# Verilator build and run of the pipeline testbench

SIM = obj_dir/Vpipe_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module pipe_tb -f all.f -o Vpipe_tb

# Pass only when the simulation prints the pass message
run: compile
	@out=$$(./$(SIM)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir
